// ==== files.f ====
hw/queue_cfg_pkg.sv
hw/wb_pkg.sv
hw/entry_bank.sv
hw/push_distributor.sv
hw/pop_gatherer.sv
hw/entry_queue_top.sv
tb/queue_checker.sv
tb/tb_entry_queue.sv

// ==== hw/entry_bank.sv ====
`timescale 1ns/10ps

module entry_bank (
	input  logic CLK,
	input  logic reset,
	input  logic flush,
	input  logic fill,
	input  queue_cfg_pkg::entry_t fill_entry,
	input  logic drain,
	output queue_cfg_pkg::entry_t head
);

	queue_cfg_pkg::entry_t slot [queue_cfg_pkg::BANK_DEPTH];
	logic [queue_cfg_pkg::SLOT_W-1:0] fill_slot;
	logic [queue_cfg_pkg::SLOT_W-1:0] drain_slot;
	// local fill level, one bit wider than the slot index
	logic [queue_cfg_pkg::SLOT_W:0] level;

	// slot storage only moves on fill
	always_ff @(posedge CLK) begin
		if (fill) begin
			slot[fill_slot] <= fill_entry;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			fill_slot <= '0;
			drain_slot <= '0;
		end else begin
			// both counters wrap over the four slots
			if (fill) begin
				fill_slot <= fill_slot + 1'b1;
			end
			if (drain) begin
				drain_slot <= drain_slot + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			level <= '0;
		end else begin
			level <= level + {{queue_cfg_pkg::SLOT_W{1'b0}}, fill}
				- {{queue_cfg_pkg::SLOT_W{1'b0}}, drain};
		end
	end

	// oldest entry still held by this bank
	assign head = slot[drain_slot];

	// global free space check must keep every bank from overflowing
	assert property (@(posedge CLK) disable iff (reset)
		fill |-> (level < queue_cfg_pkg::BANK_DEPTH));

	// pop side only drains banks whose head is shown as valid
	assert property (@(posedge CLK) disable iff (reset)
		drain |-> (level != '0));

endmodule

// ==== hw/entry_queue_top.sv ====
`timescale 1ns/10ps

module entry_queue_top (
	input  logic CLK,
	input  logic reset,
	input  wb_pkg::wb_req_t bus_req,
	output wb_pkg::wb_rsp_t bus_rsp,
	output queue_cfg_pkg::pop_view_t pop_view,
	input  logic [1:0] pop_count
);

	logic [queue_cfg_pkg::PTR_W-1:0] rd_ptr;
	logic [queue_cfg_pkg::PTR_W-1:0] wr_ptr;
	logic [queue_cfg_pkg::PTR_W-1:0] occupancy;
	logic [queue_cfg_pkg::NUM_BANKS-1:0] fill;
	logic [queue_cfg_pkg::NUM_BANKS-1:0] drain;
	queue_cfg_pkg::entry_t [queue_cfg_pkg::NUM_BANKS-1:0] fill_entry;
	queue_cfg_pkg::entry_t [queue_cfg_pkg::NUM_BANKS-1:0] bank_head;
	logic flush;

	// bus side, owns the write pointer and the full condition
	push_distributor u_push (
		.CLK(CLK),
		.reset(reset),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.rd_ptr(rd_ptr),
		.wr_ptr(wr_ptr),
		.occupancy(occupancy),
		.fill(fill),
		.fill_entry(fill_entry),
		.flush(flush)
	);

	// stream side, owns the read pointer and the empty condition
	pop_gatherer u_pop (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.wr_ptr(wr_ptr),
		.rd_ptr(rd_ptr),
		.occupancy(occupancy),
		.bank_head(bank_head),
		.drain(drain),
		.pop_view(pop_view),
		.pop_count(pop_count)
	);

	// four banks, each fills and drains in its own slot order
	for (genvar b = 0; b < queue_cfg_pkg::NUM_BANKS; b++) begin : g_bank
		entry_bank u_bank (
			.CLK(CLK),
			.reset(reset),
			.flush(flush),
			.fill(fill[b]),
			.fill_entry(fill_entry[b]),
			.drain(drain[b]),
			.head(bank_head[b])
		);
	end

endmodule

// ==== hw/pop_gatherer.sv ====
`timescale 1ns/10ps

module pop_gatherer (
	input  logic CLK,
	input  logic reset,
	input  logic flush,
	input  logic [queue_cfg_pkg::PTR_W-1:0] wr_ptr,
	output logic [queue_cfg_pkg::PTR_W-1:0] rd_ptr,
	output logic [queue_cfg_pkg::PTR_W-1:0] occupancy,
	input  queue_cfg_pkg::entry_t [queue_cfg_pkg::NUM_BANKS-1:0] bank_head,
	output logic [queue_cfg_pkg::NUM_BANKS-1:0] drain,
	output queue_cfg_pkg::pop_view_t pop_view,
	input  logic [1:0] pop_count
);

	queue_cfg_pkg::bank_idx_t rd_bank;
	queue_cfg_pkg::bank_idx_t next_bank;

	// wrap bit makes the difference exact from 0 to 16
	assign occupancy = wr_ptr - rd_ptr;

	// oldest entry sits in the bank under the read pointer
	assign rd_bank = rd_ptr[queue_cfg_pkg::BANK_IDX_W-1:0];
	assign next_bank = rd_bank + 1'b1;

	always_comb begin
		pop_view.head[0] = bank_head[rd_bank];
		pop_view.head[1] = bank_head[next_bank];
		// valid count is occupancy capped at two
		if (occupancy > queue_cfg_pkg::POP_MAX) begin
			pop_view.count = 2'(queue_cfg_pkg::POP_MAX);
		end else begin
			pop_view.count = occupancy[1:0];
		end
	end

	// drain strobes follow the pop count, flush overrides any pop
	always_comb begin
		drain = '0;
		if (!flush) begin
			if (pop_count >= 2'd1) begin
				drain[rd_bank] = 1'b1;
			end
			if (pop_count >= 2'd2) begin
				drain[next_bank] = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			rd_ptr <= '0;
		end else begin
			rd_ptr <= rd_ptr + queue_cfg_pkg::ptr_t'(pop_count);
		end
	end

	// consumer has no handshake, it may only take what is shown
	assert property (@(posedge CLK) disable iff (reset)
		pop_count <= pop_view.count);

endmodule

// ==== hw/push_distributor.sv ====
`timescale 1ns/10ps

module push_distributor (
	input  logic CLK,
	input  logic reset,
	input  wb_pkg::wb_req_t bus_req,
	output wb_pkg::wb_rsp_t bus_rsp,
	input  logic [queue_cfg_pkg::PTR_W-1:0] rd_ptr,
	output logic [queue_cfg_pkg::PTR_W-1:0] wr_ptr,
	input  logic [queue_cfg_pkg::PTR_W-1:0] occupancy,
	output logic [queue_cfg_pkg::NUM_BANKS-1:0] fill,
	output queue_cfg_pkg::entry_t [queue_cfg_pkg::NUM_BANKS-1:0] fill_entry,
	output logic flush
);

	wb_pkg::bus_word_u word;
	queue_cfg_pkg::ptr_t used;
	queue_cfg_pkg::ptr_t free;
	logic is_push;
	logic is_ctrl;
	logic room;
	logic ack_q;
	logic push_ack;

	// write data decoded both ways, adr picks the meaning
	assign word = bus_req.dat;
	assign is_push = bus_req.we && (bus_req.adr == wb_pkg::ADR_PUSH);
	assign is_ctrl = bus_req.we && (bus_req.adr == wb_pkg::ADR_CTRL);

	// free space seen from the read pointer of the pop side
	assign used = wr_ptr - rd_ptr;
	assign free = queue_cfg_pkg::ptr_t'(queue_cfg_pkg::QUEUE_DEPTH) - used;

	// reads and control never wait, a push waits for room
	// pops can only widen the room before the ack cycle
	assign room = !is_push || (queue_cfg_pkg::ptr_t'(word.push.count) <= free);

	always_ff @(posedge CLK) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			// single cycle ack, never on the cycle right after one
			ack_q <= bus_req.cyc && bus_req.stb && !ack_q && room;
		end
	end

	// bundle lands and flush fires in the ack cycle itself
	assign push_ack = ack_q && is_push;
	assign flush = ack_q && is_ctrl && word.ctrl.flush;

	always_comb begin
		bus_rsp.ack = ack_q;
		bus_rsp.dat = '0;
		// status read returns occupancy as seen during ack
		if (ack_q && !bus_req.we) begin
			bus_rsp.dat[queue_cfg_pkg::PTR_W-1:0] = occupancy;
		end
	end

	// entry k of the bundle goes to bank (wr_ptr + k) mod 4
	always_comb begin
		queue_cfg_pkg::bank_idx_t k;
		fill = '0;
		fill_entry = '0;
		for (int b = 0; b < queue_cfg_pkg::NUM_BANKS; b++) begin
			// position of bank b inside this bundle
			k = queue_cfg_pkg::bank_idx_t'(b) - wr_ptr[queue_cfg_pkg::BANK_IDX_W-1:0];
			if (k < queue_cfg_pkg::PUSH_MAX) begin
				fill_entry[b] = word.push.entry[k];
				fill[b] = push_ack && (k < word.push.count);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wr_ptr <= '0;
		end else if (push_ack) begin
			wr_ptr <= wr_ptr + queue_cfg_pkg::ptr_t'(word.push.count);
		end
	end

	// a bundle only lands while the queue still has room for all of it
	assert property (@(posedge CLK) disable iff (reset)
		push_ack |-> (queue_cfg_pkg::ptr_t'(word.push.count) <= free));

	// ack only answers a request the producer still holds
	assert property (@(posedge CLK) disable iff (reset)
		bus_rsp.ack |-> (bus_req.cyc && bus_req.stb));

endmodule

// ==== hw/queue_cfg_pkg.sv ====
package queue_cfg_pkg;

	// payload width of one queue entry
	localparam int ENTRY_W = 8;

	// storage split into equal banks, filled and drained in rotation
	localparam int NUM_BANKS  = 4;
	localparam int BANK_DEPTH = 4;
	localparam int QUEUE_DEPTH = NUM_BANKS * BANK_DEPTH;
	localparam int BANK_IDX_W = 2;

	// most entries moved per bus push and per consumer pop
	localparam int PUSH_MAX = 3;
	localparam int POP_MAX  = 2;

	// global pointer carries one wrap bit above the 16-entry index
	localparam int PTR_W  = 5;
	localparam int SLOT_W = 2;

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [BANK_IDX_W-1:0] bank_idx_t;

	typedef struct packed {
		logic [ENTRY_W-1:0] payload;
	} entry_t;

	// head[0] is the oldest entry
	// count tells how many heads are valid (0 to 2)
	typedef struct packed {
		logic [1:0] count;
		entry_t [POP_MAX-1:0] head;
	} pop_view_t;

endpackage

// ==== hw/wb_pkg.sv ====
package wb_pkg;

	localparam int WB_DW = 32;

	// one address bit selects push data or control
	localparam logic ADR_PUSH = 1'b0;
	localparam logic ADR_CTRL = 1'b1;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic adr;
		logic [WB_DW-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WB_DW-1:0] dat;
	} wb_rsp_t;

	// count in the top two bits, entry 0 in the lowest byte
	typedef struct packed {
		logic [1:0] count;
		logic [WB_DW-2-queue_cfg_pkg::PUSH_MAX*queue_cfg_pkg::ENTRY_W-1:0] rsvd;
		queue_cfg_pkg::entry_t [queue_cfg_pkg::PUSH_MAX-1:0] entry;
	} push_word_t;

	// only bit 0 carries meaning, the rest reads back as don't care
	typedef struct packed {
		logic [WB_DW-2:0] rsvd;
		logic flush;
	} ctrl_word_t;

	// the write data word, seen as push or control depending on adr
	typedef union packed {
		push_word_t push;
		ctrl_word_t ctrl;
	} bus_word_u;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_entry_queue -f files.f \
	-o sim_entry_queue && ./obj_dir/sim_entry_queue > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb/queue_checker.sv ====
`timescale 1ns/10ps

module queue_checker (
	input  logic CLK,
	input  logic reset,
	input  wb_pkg::wb_req_t bus_req,
	input  wb_pkg::wb_rsp_t bus_rsp,
	input  queue_cfg_pkg::pop_view_t pop_view,
	input  logic [1:0] pop_count,
	input  int test_id,
	output int model_level,
	output int total_errors,
	output logic summary_done
);

	// reference queue, oldest entry at index 0
	queue_cfg_pkg::entry_t model_q[$];
	// ack the bus should show in the cycle now running
	logic exp_ack = 1'b0;
	int cur_id = 0;
	int n_checks = 0;
	int n_errors = 0;
	int sum_tests = 0;
	int sum_checks = 0;
	int sum_errors = 0;
	int sum_failed = 0;

	function automatic string test_name(input int id);
		case (id)
			1: return "single_order";
			2: return "bundle_mix";
			3: return "full_stall";
			4: return "flush_clear";
			5: return "status_read";
			6: return "pop_hold";
			default: return "none";
		endcase
	endfunction

	task automatic compare(input string what, input int expected, input int actual);
		n_checks++;
		if (expected != actual) begin
			n_errors++;
			$display("MISMATCH %s %s: expected %0d actual %0d",
				test_name(cur_id), what, expected, actual);
		end
	endtask

	task automatic report(input string what);
		n_errors++;
		$display("ERROR %s: %s", test_name(cur_id), what);
	endtask

	// result line of the test that just ended
	task automatic close_test();
		if (cur_id >= 1 && cur_id <= 6) begin
			$display("test %-12s checks %0d errors %0d %s", test_name(cur_id),
				n_checks, n_errors, (n_errors == 0) ? "ok" : "failed");
			sum_tests++;
			sum_checks += n_checks;
			sum_errors += n_errors;
			if (n_errors != 0) begin
				sum_failed++;
			end
		end
		n_checks = 0;
		n_errors = 0;
	endtask

	// everything sampled here is the value held during the past cycle
	always @(posedge CLK) begin
		wb_pkg::bus_word_u word;
		int shown;
		word = bus_req.dat;
		if (reset) begin
			model_q.delete();
			exp_ack = 1'b0;
			summary_done <= 1'b0;
			total_errors <= 0;
		end else begin
			if (test_id != cur_id) begin
				close_test();
				cur_id = test_id;
			end
			// view shows the model head, count capped at two
			shown = (model_q.size() > queue_cfg_pkg::POP_MAX) ? queue_cfg_pkg::POP_MAX
				: model_q.size();
			compare("valid count", shown, int'(pop_view.count));
			for (int i = 0; i < shown; i++) begin
				compare("head entry", int'(model_q[i].payload), int'(pop_view.head[i].payload));
			end
			// ack comes one cycle after a request that finds room, for one cycle only
			compare("bus ack", int'(exp_ack), int'(bus_rsp.ack));
			exp_ack = bus_req.cyc && bus_req.stb && !bus_rsp.ack
				&& !(bus_req.we && bus_req.adr == wb_pkg::ADR_PUSH
				&& model_q.size() + int'(word.push.count) > queue_cfg_pkg::QUEUE_DEPTH);
			// status read sees occupancy before this edge's push and pop
			if (bus_rsp.ack && !bus_req.we) begin
				compare("occupancy read", model_q.size(), int'(bus_rsp.dat));
			end
			if (bus_rsp.ack && bus_req.we && bus_req.adr == wb_pkg::ADR_CTRL
				&& word.ctrl.flush) begin
				// flush drops any pop of the ack cycle
				model_q.delete();
			end else begin
				for (int i = 0; i < int'(pop_count) && model_q.size() > 0; i++) begin
					void'(model_q.pop_front());
				end
				if (bus_rsp.ack && bus_req.we && bus_req.adr == wb_pkg::ADR_PUSH) begin
					if (model_q.size() + int'(word.push.count) > queue_cfg_pkg::QUEUE_DEPTH) begin
						report("bundle acked without room in the queue");
					end
					for (int k = 0; k < int'(word.push.count); k++) begin
						model_q.push_back(word.push.entry[k]);
					end
				end
			end
			if (test_id == 7 && !summary_done) begin
				$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
					sum_tests, sum_failed, sum_checks, sum_errors);
				total_errors <= sum_errors;
				summary_done <= 1'b1;
			end
		end
		model_level <= model_q.size();
	end

endmodule

// ==== tb/tb_entry_queue.sv ====
`timescale 1ns/10ps

module tb_entry_queue;

	localparam logic [31:0] SEED = 32'hb8c3ce1e;
	// bus transactions per test, the cycle limit scales with their sum
	localparam int N_SINGLE = 20;
	localparam int N_MIX = 100;
	localparam int N_FULL = 8;
	localparam int N_FLUSH = 24;
	localparam int N_STATUS = 40;
	localparam int N_HOLD = 5;
	localparam int N_TOTAL = N_SINGLE + N_MIX + N_FULL + N_FLUSH + N_STATUS + N_HOLD;
	localparam int CYCLE_LIMIT = N_TOTAL * 40;
	localparam int STALL_CYCLES = 40;
	// consumer modes
	localparam int POP_NONE = 0;
	localparam int POP_ONE = 1;
	localparam int POP_RAND = 2;
	localparam wb_pkg::wb_req_t REQ_IDLE = '0;

	logic CLK;
	logic reset;
	wb_pkg::wb_req_t bus_req;
	wb_pkg::wb_rsp_t bus_rsp;
	queue_cfg_pkg::pop_view_t pop_view;
	logic [1:0] pop_count = 2'd0;
	logic [7:0] seq_byte;
	int test_id;
	int pop_mode;
	int cycle_count = 0;
	int chk_level;
	int chk_errors;
	logic chk_done;

	entry_queue_top u_dut (
		.CLK(CLK),
		.reset(reset),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.pop_view(pop_view),
		.pop_count(pop_count)
	);

	queue_checker u_chk (
		.CLK(CLK),
		.reset(reset),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.pop_view(pop_view),
		.pop_count(pop_count),
		.test_id(test_id),
		.model_level(chk_level),
		.total_errors(chk_errors),
		.summary_done(chk_done)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("TIMEOUT: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// entries shown after this edge, from the level and what commits now
	function automatic int level_after_edge();
		wb_pkg::bus_word_u w;
		int lvl;
		w = bus_req.dat;
		lvl = chk_level - int'(pop_count);
		if (bus_rsp.ack && bus_req.we && bus_req.adr == wb_pkg::ADR_PUSH) begin
			lvl = lvl + int'(w.push.count);
		end else if (bus_rsp.ack && bus_req.we && w.ctrl.flush) begin
			lvl = 0;
		end
		return lvl;
	endfunction

	// consumer, never pops more than the view will show
	always @(posedge CLK) begin
		int avail;
		avail = level_after_edge();
		if (avail > queue_cfg_pkg::POP_MAX) begin
			avail = queue_cfg_pkg::POP_MAX;
		end
		if (reset || pop_mode == POP_NONE) begin
			pop_count <= 2'd0;
		end else if (pop_mode == POP_ONE) begin
			pop_count <= (avail > 0) ? 2'd1 : 2'd0;
		end else begin
			pop_count <= 2'($urandom_range(avail, 0));
		end
	end

	// classic cycle, request held until the ack cycle ends
	task automatic bus_access(input logic we, input logic adr, input logic [31:0] dat);
		wb_pkg::wb_req_t req;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		@(posedge CLK);
		bus_req <= req;
		@(posedge CLK);
		while (!bus_rsp.ack) @(posedge CLK);
		bus_req <= REQ_IDLE;
	endtask

	// running payloads so a lost or doubled entry shows up
	task automatic push_bundle(input int count);
		wb_pkg::push_word_t w;
		w.count = 2'(count);
		w.rsvd = '0;
		for (int k = 0; k < queue_cfg_pkg::PUSH_MAX; k++) begin
			w.entry[k].payload = (k < count) ? seq_byte + 8'(k) : 8'($urandom);
		end
		seq_byte = seq_byte + 8'(count);
		bus_access(1'b1, wb_pkg::ADR_PUSH, w);
	endtask

	task automatic start_test(input int id, input int mode);
		@(posedge CLK);
		test_id <= id;
		pop_mode <= mode;
	endtask

	task automatic drain_queue();
		@(posedge CLK);
		pop_mode <= POP_RAND;
		@(posedge CLK);
		while (chk_level != 0) @(posedge CLK);
	endtask

	initial begin
		int flush_at;
		void'($urandom(SEED));
		seq_byte = 8'($urandom);
		reset = 1'b1;
		bus_req = REQ_IDLE;
		test_id = 0;
		pop_mode = POP_NONE;
		repeat (5) @(posedge CLK);
		reset <= 1'b0;
		start_test(1, POP_ONE);
		repeat (N_SINGLE) push_bundle(1);
		drain_queue();
		start_test(2, POP_RAND);
		repeat (N_MIX) push_bundle($urandom_range(3, 0));
		drain_queue();
		// consumer idle until the queue is full and a bundle stalls
		start_test(3, POP_NONE);
		fork
			repeat (N_FULL) push_bundle(3);
			begin
				repeat (STALL_CYCLES) @(posedge CLK);
				pop_mode <= POP_RAND;
			end
		join
		drain_queue();
		start_test(4, POP_RAND);
		flush_at = $urandom_range(N_FLUSH - 5, 5);
		for (int i = 0; i < N_FLUSH; i++) begin
			if (i == flush_at) begin
				bus_access(1'b1, wb_pkg::ADR_CTRL, 32'h1);
			end else begin
				push_bundle($urandom_range(3, 1));
			end
		end
		drain_queue();
		start_test(5, POP_RAND);
		for (int i = 0; i < N_STATUS; i++) begin
			if ($urandom_range(1, 0) == 1) begin
				bus_access(1'b0, wb_pkg::ADR_PUSH, 32'h0);
			end else begin
				push_bundle($urandom_range(3, 0));
			end
		end
		drain_queue();
		// at most 15 entries, so no push stalls with the consumer idle
		start_test(6, POP_NONE);
		repeat (N_HOLD) push_bundle($urandom_range(3, 0));
		drain_queue();
		start_test(7, POP_NONE);
		@(posedge CLK);
		while (!chk_done) @(posedge CLK);
		if (chk_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
